// File: src/enigma_pkg.sv
/*
 * enigma shared definitions
 * word type, table depths, table and switch enums, whitening seed
 * and the fixed rotor B step permutation
 */

package enigma_pkg;

  // ==============================
  // word and table sizes
  // ==============================
  localparam int WORD_W      = 6;
  localparam int ROTOR_DEPTH = 64;
  localparam int PLUG_DEPTH  = 32;

  typedef logic [WORD_W-1:0] word_t;

  // table_idx encoding, 3 selects nothing
  typedef enum logic [1:0] {
    TBL_ROTOR_A   = 2'd0,
    TBL_PLUGBOARD = 2'd1,
    TBL_ROTOR_B   = 2'd2
  } table_sel_e;

  // bit switch modes
  typedef enum logic [1:0] {
    SW_INVERT      = 2'd0,
    SW_REVERSE     = 2'd1,
    SW_SWAP_PAIRS  = 2'd2,
    SW_SWAP_HALVES = 2'd3
  } sw_mode_e;

  // ==============================
  // constants
  // ==============================
  localparam word_t LFSR_SEED = 6'b000001;

  // new entry i takes old entry ROTOR_B_STEP[i] xor r
  localparam word_t ROTOR_B_STEP [ROTOR_DEPTH] = '{
    6'd56, 6'd61, 6'd25, 6'd17, 6'd42, 6'd48, 6'd23, 6'd43,
    6'd10, 6'd28, 6'd58, 6'd24, 6'd21, 6'd29, 6'd18, 6'd38,
    6'd26, 6'd13, 6'd57, 6'd6,  6'd22, 6'd47, 6'd8,  6'd40,
    6'd54, 6'd2,  6'd32, 6'd63, 6'd14, 6'd34, 6'd60, 6'd55,
    6'd49, 6'd16, 6'd9,  6'd44, 6'd5,  6'd3,  6'd53, 6'd46,
    6'd51, 6'd39, 6'd30, 6'd11, 6'd15, 6'd4,  6'd36, 6'd59,
    6'd50, 6'd19, 6'd35, 6'd52, 6'd62, 6'd1,  6'd37, 6'd7,
    6'd12, 6'd45, 6'd31, 6'd27, 6'd41, 6'd20, 6'd0,  6'd33
  };

endpackage

// File: src/enigma_ctrl.sv
/*
 * enigma input control
 * registers the incoming word and strobes, decodes the table write enables
 */

`timescale 1ns/1ps

module enigma_ctrl (
  input  logic              clk,
  input  logic              srst_n,
  input  logic              load,
  input  logic              encrypt,
  input  logic [1:0]        table_idx,
  input  enigma_pkg::word_t code_in,
  output enigma_pkg::word_t word_q,
  output logic              enc_valid_q,
  output enigma_pkg::word_t load_word,
  output logic              pb_we,
  output logic              ra_we,
  output logic              rb_we
);

  enigma_pkg::table_sel_e table_sel;
  enigma_pkg::word_t      word_r;

  assign table_sel = enigma_pkg::table_sel_e'(table_idx);

  // control strobes
  always_ff @(posedge clk) begin
    if (!srst_n) begin
      enc_valid_q <= 1'b0;
      pb_we       <= 1'b0;
      ra_we       <= 1'b0;
      rb_we       <= 1'b0;
    end else begin
      enc_valid_q <= encrypt;
      pb_we       <= load && (table_sel == enigma_pkg::TBL_PLUGBOARD);
      ra_we       <= load && (table_sel == enigma_pkg::TBL_ROTOR_A);
      rb_we       <= load && (table_sel == enigma_pkg::TBL_ROTOR_B);
    end
  end

  // one word register, shared by the cipher path and the table writes
  always_ff @(posedge clk) begin
    word_r <= code_in;
  end

  assign word_q    = word_r;
  assign load_word = word_r;

  // ==============================
  // input protocol checks
  // ==============================
  a_load_xor_encrypt : assert property (@(posedge clk) disable iff (!srst_n)
    load |-> !encrypt);

  a_one_table_we : assert property (@(posedge clk) disable iff (!srst_n)
    $onehot0({pb_we, ra_we, rb_we}));

  a_valid_table_idx : assert property (@(posedge clk) disable iff (!srst_n)
    load |-> (table_idx != 2'd3));

endmodule

// File: src/plugboard.sv
/*
 * plugboard stage
 * 32 entry pair table, a matching word is swapped with its partner
 */

`timescale 1ns/1ps

module plugboard (
  input  logic              clk,
  input  logic              srst_n,
  input  logic              we,
  input  enigma_pkg::word_t load_word,
  input  enigma_pkg::word_t in_word,
  input  logic              in_valid,
  output enigma_pkg::word_t out_word,
  output logic              out_valid
);

  enigma_pkg::word_t mem [enigma_pkg::PLUG_DEPTH];
  enigma_pkg::word_t swap_word;

  // ==============================
  // table load
  // ==============================
  // new word enters at entry 0, older ones move up
  always_ff @(posedge clk) begin
    if (we) begin
      mem[0] <= load_word;
      for (int i = 1; i < enigma_pkg::PLUG_DEPTH; i++) begin
        mem[i] <= mem[i-1];
      end
    end
  end

  // ==============================
  // pair lookup
  // ==============================
  // scan downwards so the lowest matching index wins
  always_comb begin
    swap_word = in_word;
    for (int i = enigma_pkg::PLUG_DEPTH - 1; i >= 0; i--) begin
      if (mem[i] == in_word) begin
        // partner sits at the other index of the pair
        swap_word = mem[i ^ 1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!srst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    out_word <= swap_word;
  end

endmodule

// File: src/rotor_a.sv
/*
 * rotor A stage
 * 64 entry table read at word plus a running offset,
 * the offset advances by the low bits of each value read
 */

`timescale 1ns/1ps

module rotor_a (
  input  logic              clk,
  input  logic              srst_n,
  input  logic              we,
  input  enigma_pkg::word_t load_word,
  input  enigma_pkg::word_t in_word,
  input  logic              in_valid,
  output enigma_pkg::word_t out_word,
  output logic              out_valid
);

  enigma_pkg::word_t mem [enigma_pkg::ROTOR_DEPTH];
  enigma_pkg::word_t offset;
  enigma_pkg::word_t rd_addr;
  enigma_pkg::word_t rd_word;

  // ==============================
  // table load
  // ==============================
  // new word enters at the top, older ones move down
  always_ff @(posedge clk) begin
    if (we) begin
      mem[enigma_pkg::ROTOR_DEPTH-1] <= load_word;
      for (int i = 0; i < enigma_pkg::ROTOR_DEPTH - 1; i++) begin
        mem[i] <= mem[i+1];
      end
    end
  end

  // address wraps mod 64 through the word width
  assign rd_addr = in_word + offset;
  assign rd_word = mem[rd_addr];

  // offset steps on the same edge the word is captured,
  // so a back to back word already sees the advance
  always_ff @(posedge clk) begin
    if (!srst_n) begin
      offset    <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
      if (in_valid) begin
        offset <= offset + enigma_pkg::word_t'(rd_word[1:0]);
      end
    end
  end

  always_ff @(posedge clk) begin
    out_word <= rd_word;
  end

  a_offset_needs_word : assert property (@(posedge clk) disable iff (!srst_n)
    $past(srst_n) && $changed(offset) |-> $past(in_valid));

endmodule

// File: src/bit_switch.sv
/*
 * bit switch stage
 * rearranges the bits of each word by the current mode,
 * the next mode comes from the word just switched
 */

`timescale 1ns/1ps

module bit_switch (
  input  logic              clk,
  input  logic              srst_n,
  input  enigma_pkg::word_t in_word,
  input  logic              in_valid,
  output enigma_pkg::word_t out_word,
  output logic              out_valid
);

  enigma_pkg::sw_mode_e mode;
  enigma_pkg::sw_mode_e mode_nxt;

  // ==============================
  // bit rearrangement
  // ==============================
  always_comb begin
    case (mode)
      enigma_pkg::SW_INVERT:   out_word = ~in_word;
      enigma_pkg::SW_REVERSE: begin
        out_word = {in_word[0], in_word[1], in_word[2],
                    in_word[3], in_word[4], in_word[5]};
      end
      enigma_pkg::SW_SWAP_PAIRS: begin
        out_word = {in_word[4], in_word[5], in_word[2],
                    in_word[3], in_word[0], in_word[1]};
      end
      default: begin
        out_word = {in_word[2], in_word[1], in_word[0],
                    in_word[5], in_word[4], in_word[3]};
      end
    endcase
  end

  assign out_valid = in_valid;

  // ==============================
  // mode FSM
  // ==============================
  always_comb begin
    case (mode)
      enigma_pkg::SW_INVERT:     mode_nxt = enigma_pkg::sw_mode_e'(~in_word[1:0]);
      enigma_pkg::SW_REVERSE:    mode_nxt = enigma_pkg::sw_mode_e'({in_word[4], in_word[5]});
      enigma_pkg::SW_SWAP_PAIRS: mode_nxt = enigma_pkg::sw_mode_e'({in_word[0], in_word[1]});
      default:                   mode_nxt = enigma_pkg::sw_mode_e'({in_word[4], in_word[3]});
    endcase
  end

  // moves only when a word passes through
  always_ff @(posedge clk) begin
    if (!srst_n) begin
      mode <= enigma_pkg::SW_INVERT;
    end else if (in_valid) begin
      mode <= mode_nxt;
    end
  end

endmodule

// File: src/rotor_b.sv
/*
 * rotor B stage
 * 64 entry table read at the word address, the whole table
 * is permuted after every word by the low bits of the value read
 */

`timescale 1ns/1ps

module rotor_b (
  input  logic              clk,
  input  logic              we,
  input  enigma_pkg::word_t load_word,
  input  enigma_pkg::word_t in_word,
  input  logic              in_valid,
  output enigma_pkg::word_t out_word,
  output logic              out_valid
);

  enigma_pkg::word_t mem      [enigma_pkg::ROTOR_DEPTH];
  enigma_pkg::word_t step_tbl [enigma_pkg::ROTOR_DEPTH];
  enigma_pkg::word_t rot_sel;

  // ==============================
  // forward read
  // ==============================
  assign out_word  = mem[in_word];
  assign out_valid = in_valid;

  // low two bits of the read value pick the xor applied to the step source
  assign rot_sel = enigma_pkg::word_t'(out_word[1:0]);

  // permuted table for the next word
  always_comb begin
    for (int i = 0; i < enigma_pkg::ROTOR_DEPTH; i++) begin
      step_tbl[i] = mem[enigma_pkg::ROTOR_B_STEP[i] ^ rot_sel];
    end
  end

  // ==============================
  // table load and step
  // ==============================
  always_ff @(posedge clk) begin
    if (we) begin
      mem[enigma_pkg::ROTOR_DEPTH-1] <= load_word;
      for (int i = 0; i < enigma_pkg::ROTOR_DEPTH - 1; i++) begin
        mem[i] <= mem[i+1];
      end
    end else if (in_valid) begin
      mem <= step_tbl;
    end
  end

  // loads from the control stage must not overlap words in flight here
  a_no_load_during_word : assert property (@(posedge clk)
    we |-> !in_valid);

endmodule

// File: src/whitening.sv
/*
 * xor whitening and output register
 * each word is xored with a 6 bit LFSR that steps once per word
 */

`timescale 1ns/1ps

module whitening (
  input  logic              clk,
  input  logic              srst_n,
  input  enigma_pkg::word_t in_word,
  input  logic              in_valid,
  output enigma_pkg::word_t code_out,
  output logic              code_valid
);

  enigma_pkg::word_t lfsr;

  // shift left, feedback from the two top bits
  always_ff @(posedge clk) begin
    if (!srst_n) begin
      lfsr       <= enigma_pkg::LFSR_SEED;
      code_valid <= 1'b0;
    end else begin
      code_valid <= in_valid;
      if (in_valid) begin
        lfsr <= {lfsr[4:0], lfsr[4] ^ lfsr[5]};
      end
    end
  end

  always_ff @(posedge clk) begin
    code_out <= in_word ^ lfsr;
  end

endmodule

// File: src/enigma_top.sv
/*
 * enigma top level
 * ctrl, plugboard, rotor A, bit switch, rotor B and whitening in a row
 */

`timescale 1ns/1ps

module enigma_top (
  input  logic              clk,
  input  logic              srst_n,
  input  logic              load,
  input  logic              encrypt,
  input  logic [1:0]        table_idx,
  input  enigma_pkg::word_t code_in,
  output enigma_pkg::word_t code_out,
  output logic              code_valid
);

  enigma_pkg::word_t word_q;
  enigma_pkg::word_t load_word;
  enigma_pkg::word_t pb_word;
  enigma_pkg::word_t ra_word;
  enigma_pkg::word_t sw_word;
  enigma_pkg::word_t rb_word;
  logic              enc_valid_q;
  logic              pb_we;
  logic              ra_we;
  logic              rb_we;
  logic              pb_valid;
  logic              ra_valid;
  logic              sw_valid;
  logic              rb_valid;

  enigma_ctrl i_enigma_ctrl (
    .clk         (clk),
    .srst_n      (srst_n),
    .load        (load),
    .encrypt     (encrypt),
    .table_idx   (table_idx),
    .code_in     (code_in),
    .word_q      (word_q),
    .enc_valid_q (enc_valid_q),
    .load_word   (load_word),
    .pb_we       (pb_we),
    .ra_we       (ra_we),
    .rb_we       (rb_we)
  );

  // ==============================
  // cipher path
  // ==============================
  plugboard i_plugboard (
    .clk       (clk),
    .srst_n    (srst_n),
    .we        (pb_we),
    .load_word (load_word),
    .in_word   (word_q),
    .in_valid  (enc_valid_q),
    .out_word  (pb_word),
    .out_valid (pb_valid)
  );

  rotor_a i_rotor_a (
    .clk       (clk),
    .srst_n    (srst_n),
    .we        (ra_we),
    .load_word (load_word),
    .in_word   (pb_word),
    .in_valid  (pb_valid),
    .out_word  (ra_word),
    .out_valid (ra_valid)
  );

  // switch and rotor B share one cycle with the whitening register
  bit_switch i_bit_switch (
    .clk       (clk),
    .srst_n    (srst_n),
    .in_word   (ra_word),
    .in_valid  (ra_valid),
    .out_word  (sw_word),
    .out_valid (sw_valid)
  );

  rotor_b i_rotor_b (
    .clk       (clk),
    .we        (rb_we),
    .load_word (load_word),
    .in_word   (sw_word),
    .in_valid  (sw_valid),
    .out_word  (rb_word),
    .out_valid (rb_valid)
  );

  whitening i_whitening (
    .clk        (clk),
    .srst_n     (srst_n),
    .in_word    (rb_word),
    .in_valid   (rb_valid),
    .code_out   (code_out),
    .code_valid (code_valid)
  );

endmodule

// File: dv/tb_clk_gen.sv
/*
 * testbench clock and reset
 * 20 ns clock, srst_n low for 3 cycles at start and again on restart
 */

`timescale 1ns/1ps

module tb_clk_gen (
  input  logic restart,
  output logic clk,
  output logic srst_n
);

  int rst_cnt;

  initial begin
    clk     = 1'b0;
    srst_n  = 1'b0;
    rst_cnt = 3;
    forever #10 clk = ~clk;
  end

  // reset edges still to go, restart rearms the count
  always @(posedge clk) begin
    if (restart) begin
      rst_cnt <= 3;
    end else if (rst_cnt != 0) begin
      rst_cnt <= rst_cnt - 1;
    end
  end

  // reset changes on the falling edge like the other DUT inputs
  always @(negedge clk) begin
    srst_n <= (rst_cnt == 0);
  end

endmodule

// File: dv/enigma_model.svh
/*
 * enigma reference model
 * shadow tables and cipher state, one call per loaded or encrypted word
 */

`ifndef ENIGMA_MODEL_SVH
`define ENIGMA_MODEL_SVH

enigma_pkg::word_t    m_pb [enigma_pkg::PLUG_DEPTH];
enigma_pkg::word_t    m_ra [enigma_pkg::ROTOR_DEPTH];
enigma_pkg::word_t    m_rb [enigma_pkg::ROTOR_DEPTH];
enigma_pkg::word_t    m_off;
enigma_pkg::word_t    m_lfsr;
enigma_pkg::sw_mode_e m_mode;

function automatic void model_reset();
  m_off  = '0;
  m_lfsr = enigma_pkg::LFSR_SEED;
  m_mode = enigma_pkg::SW_INVERT;
endfunction

function automatic void model_load(input enigma_pkg::table_sel_e sel,
                                   input enigma_pkg::word_t w);
  case (sel)
    enigma_pkg::TBL_PLUGBOARD: begin
      for (int i = enigma_pkg::PLUG_DEPTH - 1; i > 0; i--) begin
        m_pb[i] = m_pb[i-1];
      end
      m_pb[0] = w;
    end
    enigma_pkg::TBL_ROTOR_A: begin
      for (int i = 0; i < enigma_pkg::ROTOR_DEPTH - 1; i++) begin
        m_ra[i] = m_ra[i+1];
      end
      m_ra[enigma_pkg::ROTOR_DEPTH-1] = w;
    end
    default: begin
      for (int i = 0; i < enigma_pkg::ROTOR_DEPTH - 1; i++) begin
        m_rb[i] = m_rb[i+1];
      end
      m_rb[enigma_pkg::ROTOR_DEPTH-1] = w;
    end
  endcase
endfunction

// output bit 5 down to 0 takes the listed input bit
function automatic enigma_pkg::word_t switch_bits(input enigma_pkg::word_t w,
                                                  input enigma_pkg::sw_mode_e md);
  int                src [6];
  enigma_pkg::word_t res;
  res = ~w;
  if (md != enigma_pkg::SW_INVERT) begin
    case (md)
      enigma_pkg::SW_REVERSE:    src = '{0, 1, 2, 3, 4, 5};
      enigma_pkg::SW_SWAP_PAIRS: src = '{4, 5, 2, 3, 0, 1};
      default:                   src = '{2, 1, 0, 5, 4, 3};
    endcase
    for (int k = 0; k < 6; k++) begin
      res[5-k] = w[src[k]];
    end
  end
  return res;
endfunction

function automatic enigma_pkg::word_t model_encrypt(input enigma_pkg::word_t w);
  enigma_pkg::word_t p;
  enigma_pkg::word_t a;
  enigma_pkg::word_t s;
  enigma_pkg::word_t b;
  enigma_pkg::word_t addr;
  enigma_pkg::word_t res;
  enigma_pkg::word_t old_rb [enigma_pkg::ROTOR_DEPTH];
  bit                hit;
  // plugboard, lowest matching entry wins
  p   = w;
  hit = 1'b0;
  for (int i = 0; i < enigma_pkg::PLUG_DEPTH; i++) begin
    if (!hit && m_pb[i] == w) begin
      p   = m_pb[i ^ 1];
      hit = 1'b1;
    end
  end
  addr  = p + m_off;
  a     = m_ra[addr];
  m_off = m_off + enigma_pkg::word_t'(a[1:0]);
  s     = switch_bits(a, m_mode);
  case (m_mode)
    enigma_pkg::SW_INVERT:     m_mode = enigma_pkg::sw_mode_e'(~a[1:0]);
    enigma_pkg::SW_REVERSE:    m_mode = enigma_pkg::sw_mode_e'({a[4], a[5]});
    enigma_pkg::SW_SWAP_PAIRS: m_mode = enigma_pkg::sw_mode_e'({a[0], a[1]});
    default:                   m_mode = enigma_pkg::sw_mode_e'({a[4], a[3]});
  endcase
  b      = m_rb[s];
  old_rb = m_rb;
  for (int i = 0; i < enigma_pkg::ROTOR_DEPTH; i++) begin
    m_rb[i] = old_rb[enigma_pkg::ROTOR_B_STEP[i] ^ enigma_pkg::word_t'(b[1:0])];
  end
  res    = b ^ m_lfsr;
  m_lfsr = {m_lfsr[4:0], m_lfsr[4] ^ m_lfsr[5]};
  return res;
endfunction

// first word at or above start that no plugboard entry holds
function automatic enigma_pkg::word_t unmatched_word(input enigma_pkg::word_t start);
  enigma_pkg::word_t w;
  bit                hit;
  w = start;
  for (int n = 0; n < enigma_pkg::ROTOR_DEPTH; n++) begin
    hit = 1'b0;
    for (int i = 0; i < enigma_pkg::PLUG_DEPTH; i++) begin
      if (m_pb[i] == w) begin
        hit = 1'b1;
      end
    end
    if (!hit) begin
      return w;
    end
    w = w + 1'b1;
  end
  return w;
endfunction

`endif

// File: dv/tb_enigma.sv
/*
 * enigma testbench
 * random table loads and word streams, checked by concurrent assertions
 * against the model on the first run and the recorded output on the second
 */

`timescale 1ns/1ps

module tb_enigma;

  localparam int TIMEOUT_CYCLES = 1200;

  logic              clk;
  logic              srst_n;
  logic              restart;
  logic              load;
  logic              encrypt;
  logic [1:0]        table_idx;
  enigma_pkg::word_t code_in;
  enigma_pkg::word_t code_out;
  logic              code_valid;

  enigma_pkg::word_t tbl_pb [enigma_pkg::PLUG_DEPTH];
  enigma_pkg::word_t tbl_ra [enigma_pkg::ROTOR_DEPTH];
  enigma_pkg::word_t tbl_rb [enigma_pkg::ROTOR_DEPTH];
  enigma_pkg::word_t stream_w [$];
  string             stream_name [$];
  int                stream_gap [$];
  enigma_pkg::word_t exp_q [$];
  string             name_q [$];
  enigma_pkg::word_t rec_q [$];
  enigma_pkg::word_t exp_head;
  enigma_pkg::word_t act_head;
  string             exp_name;
  int                run_no;
  int                sent_count;
  int                out_count;
  int                cycle_cnt;
  bit                enc_seen;

  `include "enigma_model.svh"

  tb_clk_gen i_tb_clk_gen (
    .restart (restart),
    .clk     (clk),
    .srst_n  (srst_n)
  );

  enigma_top i_enigma_top (
    .clk        (clk),
    .srst_n     (srst_n),
    .load       (load),
    .encrypt    (encrypt),
    .table_idx  (table_idx),
    .code_in    (code_in),
    .code_out   (code_out),
    .code_valid (code_valid)
  );

  task automatic report_fail(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  // ==============================
  // checks
  // ==============================
  a_reset_quiet : assert property (@(posedge clk) disable iff (!srst_n)
    !enc_seen |-> !code_valid)
    else report_fail("code_valid went high before any encrypt word");

  a_latency : assert property (@(posedge clk) disable iff (!srst_n)
    encrypt |-> ##4 code_valid)
    else report_fail("encrypt word gave no code_valid 4 edges later");

  a_no_extra : assert property (@(posedge clk) disable iff (!srst_n)
    code_valid |-> $past(encrypt, 4))
    else report_fail("code_valid without an encrypt word 4 edges earlier");

  a_value : assert property (@(posedge clk) disable iff (!srst_n)
    code_valid |-> (code_out == exp_head))
    else report_fail($sformatf("MISMATCH %s expected %h actual %h",
                               exp_name, exp_head, act_head));

  // expected word for the output held during this cycle
  always @(negedge clk) begin
    if (code_valid === 1'b1) begin
      assert (exp_q.size() > 0)
        else report_fail("code_valid with no encrypt word pending");
      exp_head = exp_q.pop_front();
      exp_name = name_q.pop_front();
      act_head = code_out;
      out_count++;
      if (run_no == 1) begin
        rec_q.push_back(code_out);
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      report_fail("timeout, the run did not finish in time");
    end
  end

  // ==============================
  // drive tasks
  // ==============================
  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      load    = 1'b0;
      encrypt = 1'b0;
    end
  endtask

  task automatic load_table_word(input enigma_pkg::table_sel_e sel,
                                 input enigma_pkg::word_t w);
    @(negedge clk);
    load      = 1'b1;
    encrypt   = 1'b0;
    table_idx = sel;
    code_in   = w;
    model_load(sel, w);
  endtask

  task automatic load_all_tables();
    foreach (tbl_ra[i]) load_table_word(enigma_pkg::TBL_ROTOR_A, tbl_ra[i]);
    foreach (tbl_pb[i]) load_table_word(enigma_pkg::TBL_PLUGBOARD, tbl_pb[i]);
    foreach (tbl_rb[i]) load_table_word(enigma_pkg::TBL_ROTOR_B, tbl_rb[i]);
  endtask

  // second run expects the recorded first-run output
  task automatic send_word(input enigma_pkg::word_t w, input string name);
    @(negedge clk);
    load     = 1'b0;
    encrypt  = 1'b1;
    code_in  = w;
    enc_seen = 1'b1;
    if (run_no == 1) begin
      exp_q.push_back(model_encrypt(w));
      name_q.push_back(name);
    end else begin
      exp_q.push_back(rec_q[sent_count]);
      name_q.push_back({"repeat_", name});
    end
    sent_count++;
  endtask

  task automatic send_stream();
    sent_count = 0;
    for (int k = 0; k < stream_w.size(); k++) begin
      idle_cycles(stream_gap[k]);
      send_word(stream_w[k], stream_name[k]);
    end
    idle_cycles(8);
  endtask

  // back to back with plugboard hits and misses, then random gaps
  task automatic build_stream();
    for (int k = 0; k < 40; k++) begin
      stream_gap.push_back(0);
      if (k % 4 == 1) begin
        stream_w.push_back(m_pb[$urandom_range(enigma_pkg::PLUG_DEPTH - 1, 0)]);
        stream_name.push_back("plug_hit");
      end else if (k % 4 == 3) begin
        stream_w.push_back(unmatched_word(enigma_pkg::word_t'($urandom_range(63, 0))));
        stream_name.push_back("plug_miss");
      end else begin
        stream_w.push_back(enigma_pkg::word_t'($urandom_range(63, 0)));
        stream_name.push_back("b2b_random");
      end
    end
    for (int k = 0; k < 40; k++) begin
      stream_gap.push_back($urandom_range(2, 0));
      stream_w.push_back(enigma_pkg::word_t'($urandom_range(63, 0)));
      stream_name.push_back("gap_random");
    end
  endtask

  // ==============================
  // main sequence
  // ==============================
  initial begin
    restart   = 1'b0;
    load      = 1'b0;
    encrypt   = 1'b0;
    table_idx = 2'd0;
    code_in   = '0;
    enc_seen  = 1'b0;
    run_no    = 1;
    out_count = 0;
    cycle_cnt = 0;
    void'($urandom(32'hc175_1375));
    foreach (tbl_ra[i]) tbl_ra[i] = enigma_pkg::word_t'($urandom_range(63, 0));
    foreach (tbl_pb[i]) tbl_pb[i] = enigma_pkg::word_t'($urandom_range(63, 0));
    foreach (tbl_rb[i]) tbl_rb[i] = enigma_pkg::word_t'($urandom_range(63, 0));

    @(posedge srst_n);
    model_reset();
    load_all_tables();
    build_stream();
    send_stream();

    // mid-run reset, same tables and words again
    @(negedge clk);
    restart  = 1'b1;
    enc_seen = 1'b0;
    @(negedge clk);
    restart = 1'b0;
    @(posedge srst_n);
    run_no = 2;
    model_reset();
    load_all_tables();
    send_stream();

    if (out_count == 2 * stream_w.size() && exp_q.size() == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      report_fail($sformatf("got %0d output words, expected %0d",
                            out_count, 2 * stream_w.size()));
    end
  end

endmodule

// File: all.f
+incdir+dv
src/enigma_pkg.sv
src/enigma_ctrl.sv
src/plugboard.sv
src/rotor_a.sv
src/bit_switch.sv
src/rotor_b.sv
src/whitening.sv
src/enigma_top.sv
dv/tb_clk_gen.sv
dv/tb_enigma.sv
